/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_top
FILELIST  = files.f
OBJ_DIR   = obj_dir
SIM_ARGS  = +verilator+error+limit+100
PASS_MSG  = *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* files.f */
src/zx_bus_pkg.sv
src/zx_mem_pkg.sv
src/sys_clkrst.sv
src/io_decode.sv
src/win_pager.sv
src/mem_map.sv
src/bus_readback.sv
src/zx_top.sv
test/tb_clkgen.sv
test/zx_top_sva.sv
test/tb_top.sv

/* src/bus_readback.sv */
//////////////////////////////////////////////////
// I/O read data: window readback port and FF
// for everything else
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module bus_readback (
	input  wire                  fclk,
	input  wire                  core_rst_n,
	input  wire                  rdback_stb,
	input  wire [7:0]            rdback_sel,
	input  wire                  unmapped_stb,
	input  zx_mem_pkg::win_cfg_t win [zx_mem_pkg::NUM_WIN],
	input  wire                  dos,
	output logic                 rd_valid,
	output zx_bus_pkg::io_rd_t   rd_data
);

	// selector just past the windows gives the flags byte
	localparam logic [7:0] SEL_FLAGS = 8'(zx_mem_pkg::NUM_WIN);

	logic [zx_mem_pkg::NUM_WIN-1:0] rom_bits;
	zx_bus_pkg::io_rd_t             rd_nxt;

	// rom flags, window 3 in the top bit
	always_comb
	begin
		for (int i = 0; i < zx_mem_pkg::NUM_WIN; i++)
			rom_bits[i] = win[i].rom;
	end

	always_comb
	begin
		if (unmapped_stb)
			rd_nxt = 8'hFF;
		else if (rdback_sel < SEL_FLAGS)
			rd_nxt = zx_bus_pkg::io_rd_t'(win[rdback_sel[1:0]]);
		else if (rdback_sel == SEL_FLAGS)
			rd_nxt = {3'b000, dos, rom_bits};
		else
			rd_nxt = 8'hFF;
	end

	always_ff @(posedge fclk)
	begin
		if (!core_rst_n)
			rd_valid <= 1'b0;
		else
			rd_valid <= rdback_stb | unmapped_stb;
	end

	always_ff @(posedge fclk)
	begin
		if (rdback_stb || unmapped_stb)
			rd_data <= rd_nxt;
	end

endmodule

`default_nettype wire

/* src/io_decode.sv */
//////////////////////////////////////////////////
// splits each bus strobe into page write,
// readback, unmapped read or memory access
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module io_decode (
	input  wire                                    acc_stb,
	input  zx_bus_pkg::z80_acc_t                   acc,
	output logic [zx_mem_pkg::NUM_WIN-1:0]         page_wr,
	output zx_mem_pkg::win_cfg_t                   page_data,
	output logic                                   rdback_stb,
	output logic [7:0]                             rdback_sel,
	output logic                                   unmapped_stb,
	output logic                                   mem_stb,
	output zx_bus_pkg::z80_acc_t                   mem_acc
);

	logic [7:0] port_lo;

	assign port_lo = acc.addr[7:0];

	always_comb
	begin
		page_wr      = '0;
		rdback_stb   = 1'b0;
		unmapped_stb = 1'b0;
		mem_stb      = 1'b0;

		if (acc_stb)
		begin
			case (acc.kind)
				zx_bus_pkg::ACC_M1,
				zx_bus_pkg::ACC_MEM_RD,
				zx_bus_pkg::ACC_MEM_WR:
					mem_stb = 1'b1;
				zx_bus_pkg::ACC_IO_WR:
				begin
					// window picked by a[15:14]
					if (port_lo == zx_bus_pkg::PORT_PAGE_LO)
						page_wr[acc.addr[15:14]] = 1'b1;
				end
				zx_bus_pkg::ACC_IO_RD:
				begin
					if (port_lo == zx_bus_pkg::PORT_RDBACK_LO)
						rdback_stb = 1'b1;
					else
						unmapped_stb = 1'b1;
				end
				default:
					;
			endcase
		end
	end

	// payloads ride along, only the strobes qualify them
	assign page_data  = zx_mem_pkg::win_cfg_t'(acc.wdata);
	assign rdback_sel = acc.addr[15:8];
	assign mem_acc    = acc;

endmodule

`default_nettype wire

/* src/mem_map.sv */
//////////////////////////////////////////////////
// memory access translation to ROM/RAM requests,
// plus the DOS flag switched by M1 fetches
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_map (
	input  wire                  fclk,
	input  wire                  core_rst_n,
	input  wire                  mem_stb,
	input  zx_bus_pkg::z80_acc_t mem_acc,
	input  zx_mem_pkg::win_cfg_t win [zx_mem_pkg::NUM_WIN],
	output logic                 mem_valid,
	output zx_mem_pkg::mem_req_t mem,
	output logic                 dos
);

	zx_mem_pkg::win_cfg_t sel;
	zx_mem_pkg::mem_req_t req;
	logic                 is_m1;
	logic                 dos_on;
	logic                 dos_off;

	assign sel   = win[mem_acc.addr[15:14]];
	assign is_m1 = (mem_acc.kind == zx_bus_pkg::ACC_M1);

	//////////////////////////////////////////////////
	// request forming
	//////////////////////////////////////////////////

	always_comb
	begin
		req = '0;
		if (sel.rom)
		begin
			// old DOS value, the flag change applies afterwards
			req.csrom = 1'b1;
			req.rompg = {sel.page[3:0], dos};
		end
		else
		begin
			req.ram_addr = {sel.page, mem_acc.addr[13:0]};
		end
		req.wr = (mem_acc.kind == zx_bus_pkg::ACC_MEM_WR);
	end

	always_ff @(posedge fclk)
	begin
		if (!core_rst_n)
			mem_valid <= 1'b0;
		else
			mem_valid <= mem_stb;
	end

	always_ff @(posedge fclk)
	begin
		if (mem_stb)
			mem <= req;
	end

	//////////////////////////////////////////////////
	// DOS flag
	//////////////////////////////////////////////////

	assign dos_on  = is_m1 && sel.rom && (mem_acc.addr[15:8] == zx_bus_pkg::DOS_TRAP_HI);
	assign dos_off = is_m1 && !sel.rom;

	always_ff @(posedge fclk)
	begin
		if (!core_rst_n)
			dos <= zx_mem_pkg::DOS_RST;
		else if (mem_stb && dos_on)
			dos <= 1'b1;
		else if (mem_stb && dos_off)
			dos <= 1'b0;
	end

endmodule

`default_nettype wire

/* src/sys_clkrst.sv */
//////////////////////////////////////////////////
// reset stretcher, bus reset output and the
// AY clock divider
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sys_clkrst #(
	parameter int RST_CNT_SIZE = 6,
	parameter int AY_DIV_BITS  = 4
)(
	input  wire  fclk,
	input  wire  rst_n,
	output logic core_rst_n,
	output logic res,
	output logic ay_clk
);

	// msb sets after 2**RST_CNT_SIZE cycles of rst_n high
	logic [RST_CNT_SIZE:0]  rst_cnt;
	logic [AY_DIV_BITS-1:0] ay_cnt;

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
			rst_cnt <= '0;
		else if (!rst_cnt[RST_CNT_SIZE])
			rst_cnt <= rst_cnt + 1'b1;
	end

	assign core_rst_n = rst_cnt[RST_CNT_SIZE];
	assign res        = ~core_rst_n;

	// free running divider, parked at zero in reset
	always_ff @(posedge fclk)
	begin
		if (!core_rst_n)
			ay_cnt <= '0;
		else
			ay_cnt <= ay_cnt + 1'b1;
	end

	assign ay_clk = ay_cnt[AY_DIV_BITS-1];

endmodule

`default_nettype wire

/* src/win_pager.sv */
//////////////////////////////////////////////////
// page register of one 16K address window
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module win_pager #(
	parameter int unsigned WIN = 0
)(
	input  wire                  fclk,
	input  wire                  core_rst_n,
	input  wire                  wr_stb,
	input  zx_mem_pkg::win_cfg_t wr_data,
	output zx_mem_pkg::win_cfg_t cfg
);

	// reset page and rom flag depend on the window index
	localparam zx_mem_pkg::win_cfg_t CFG_RST = zx_mem_pkg::win_rst_cfg(WIN);

	zx_mem_pkg::win_cfg_t cfg_q;

	// load on the write edge, visible from the next cycle
	always_ff @(posedge fclk)
	begin
		if (!core_rst_n)
		begin
			cfg_q <= CFG_RST;
		end
		else if (wr_stb)
		begin
			// top bit is reserved, always reads back 0
			cfg_q.zero <= 1'b0;
			cfg_q.rom  <= wr_data.rom;
			cfg_q.page <= wr_data.page;
		end
	end

	assign cfg = cfg_q;

endmodule

`default_nettype wire

/* src/zx_bus_pkg.sv */
//////////////////////////////////////////////////
// z80 bus types: access kinds, bus cycle record
// and the I/O port and trap constants
//////////////////////////////////////////////////

`default_nettype none

package zx_bus_pkg;

	// kind of bus cycle, one per strobe
	typedef enum logic [2:0]
	{
		ACC_M1     = 3'd0,
		ACC_MEM_RD = 3'd1,
		ACC_MEM_WR = 3'd2,
		ACC_IO_RD  = 3'd3,
		ACC_IO_WR  = 3'd4
	} acc_kind_e;

	// one complete bus cycle as seen by the core
	typedef struct packed
	{
		logic [15:0] addr;
		logic [7:0]  wdata;
		acc_kind_e   kind;
	} z80_acc_t;

	// data returned to the cpu on I/O reads
	typedef logic [7:0] io_rd_t;

	// page port xxF7, written with the window in a[15:14]
	localparam logic [7:0] PORT_PAGE_LO = 8'hF7;

	// readback port xxBE, selector in the high byte
	localparam logic [7:0] PORT_RDBACK_LO = 8'hBE;

	// fetch from 3Dxx in ROM switches DOS on
	localparam logic [7:0] DOS_TRAP_HI = 8'h3D;

endpackage

`default_nettype wire

/* src/zx_mem_pkg.sv */
//////////////////////////////////////////////////
// memory side types: window configuration,
// translated requests and reset values
//////////////////////////////////////////////////

`default_nettype none

package zx_mem_pkg;

	// four 16K windows across the z80 address space
	localparam int NUM_WIN = 4;

	// window config, same layout as the port byte
	typedef struct packed
	{
		logic       zero;
		logic       rom;
		logic [5:0] page;
	} win_cfg_t;

	// translated memory access going out to ROM or RAM
	typedef struct packed
	{
		logic        csrom;
		logic [4:0]  rompg;
		logic [19:0] ram_addr;
		logic        wr;
	} mem_req_t;

	// DOS is off after reset
	localparam logic DOS_RST = 1'b0;

	// window n starts at page n, only window 0 maps ROM
	function automatic win_cfg_t win_rst_cfg(input int unsigned win);
		win_cfg_t cfg;
		cfg.zero = 1'b0;
		cfg.rom  = (win == 0);
		cfg.page = 6'(win);
		return cfg;
	endfunction

endpackage

`default_nettype wire

/* src/zx_top.sv */
//////////////////////////////////////////////////
// paging core top level
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module zx_top #(
	parameter int RST_CNT_SIZE = 6,
	parameter int AY_DIV_BITS  = 4
)(
	input  wire                  fclk,
	input  wire                  rst_n,
	input  wire                  acc_stb,
	input  zx_bus_pkg::z80_acc_t acc,
	output logic                 mem_valid,
	output zx_mem_pkg::mem_req_t mem,
	output logic                 rd_valid,
	output zx_bus_pkg::io_rd_t   rd_data,
	output logic                 res,
	output logic                 ay_clk
);

	logic                           core_rst_n;
	logic [zx_mem_pkg::NUM_WIN-1:0] page_wr;
	zx_mem_pkg::win_cfg_t           page_data;
	logic                           rdback_stb;
	logic [7:0]                     rdback_sel;
	logic                           unmapped_stb;
	logic                           mem_stb;
	zx_bus_pkg::z80_acc_t           mem_acc;
	zx_mem_pkg::win_cfg_t           win_cfg [zx_mem_pkg::NUM_WIN];
	logic                           dos;

	sys_clkrst #(
		.RST_CNT_SIZE (RST_CNT_SIZE),
		.AY_DIV_BITS  (AY_DIV_BITS )
	) u_clkrst (
		.fclk       (fclk      ),
		.rst_n      (rst_n     ),
		.core_rst_n (core_rst_n),
		.res        (res       ),
		.ay_clk     (ay_clk    )
	);

	io_decode u_decode (
		.acc_stb      (acc_stb     ),
		.acc          (acc         ),
		.page_wr      (page_wr     ),
		.page_data    (page_data   ),
		.rdback_stb   (rdback_stb  ),
		.rdback_sel   (rdback_sel  ),
		.unmapped_stb (unmapped_stb),
		.mem_stb      (mem_stb     ),
		.mem_acc      (mem_acc     )
	);

	//////////////////////////////////////////////////
	// window page registers
	//////////////////////////////////////////////////

	for (genvar g = 0; g < zx_mem_pkg::NUM_WIN; g++)
	begin : gen_win
		win_pager #(
			.WIN (g)
		) u_pager (
			.fclk       (fclk      ),
			.core_rst_n (core_rst_n),
			.wr_stb     (page_wr[g]),
			.wr_data    (page_data ),
			.cfg        (win_cfg[g])
		);
	end

	mem_map u_map (
		.fclk       (fclk      ),
		.core_rst_n (core_rst_n),
		.mem_stb    (mem_stb   ),
		.mem_acc    (mem_acc   ),
		.win        (win_cfg   ),
		.mem_valid  (mem_valid ),
		.mem        (mem       ),
		.dos        (dos       )
	);

	bus_readback u_rdback (
		.fclk         (fclk        ),
		.core_rst_n   (core_rst_n  ),
		.rdback_stb   (rdback_stb  ),
		.rdback_sel   (rdback_sel  ),
		.unmapped_stb (unmapped_stb),
		.win          (win_cfg     ),
		.dos          (dos         ),
		.rd_valid     (rd_valid    ),
		.rd_data      (rd_data     )
	);

endmodule

`default_nettype wire

/* test/tb_clkgen.sv */
//////////////////////////////////////////////////
// testbench clock source
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
	parameter int PERIOD = 40
)(
	output logic fclk
);

	initial
	begin
		fclk = 1'b0;
	end

	// half period high, half low
	always #(PERIOD / 2) fclk = ~fclk;

endmodule

`default_nettype wire

/* test/tb_top.sv */
//////////////////////////////////////////////////
// paging core testbench: reset, readback, paging,
// DOS switching and unmapped ports
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_top;

	localparam int PERIOD     = 40;
	localparam int N_RAND     = 64;
	localparam int N_UNM      = 16;
	// reset config has 9 accesses, paging 3 per loop, DOS 10 and unmapped 4 per loop
	localparam int N_ACC      = 9 + 3 * N_RAND + 10 + 4 * N_UNM;
	localparam int RST_CYCLES = 8 + 64 + 40;
	localparam int WD_CYCLES  = N_ACC * 4 + RST_CYCLES;

	logic                 fclk;
	logic                 rst_n;
	logic                 acc_stb;
	zx_bus_pkg::z80_acc_t acc;
	logic                 mem_valid;
	zx_mem_pkg::mem_req_t mem;
	logic                 rd_valid;
	zx_bus_pkg::io_rd_t   rd_data;
	logic                 res;
	logic                 ay_clk;

	integer seed;
	int     n_tests;
	int     n_checks;
	int     n_errors;
	int     test_err0;

	// reference state of the windows and the DOS flag
	zx_mem_pkg::win_cfg_t model_win [4];
	logic                 model_dos;

	zx_mem_pkg::mem_req_t exp_mem_q [$];
	zx_bus_pkg::io_rd_t   exp_rd_q [$];

	tb_clkgen #(.PERIOD(PERIOD)) u_clk (.fclk(fclk));

	zx_top dut (
		.fclk      (fclk     ),
		.rst_n     (rst_n    ),
		.acc_stb   (acc_stb  ),
		.acc       (acc      ),
		.mem_valid (mem_valid),
		.mem       (mem      ),
		.rd_valid  (rd_valid ),
		.rd_data   (rd_data  ),
		.res       (res      ),
		.ay_clk    (ay_clk   )
	);

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	task automatic model_reset();
		for (int i = 0; i < 4; i++)
		begin
			model_win[i].zero = 1'b0;
			model_win[i].rom  = (i == 0);
			model_win[i].page = 6'(i);
		end
		model_dos = 1'b0;
	endtask

	// ROM page nibble over DOS or RAM page over offset
	function automatic zx_mem_pkg::mem_req_t ref_mem(input zx_bus_pkg::z80_acc_t a);
		zx_mem_pkg::win_cfg_t w;
		zx_mem_pkg::mem_req_t r;
		w = model_win[a.addr[15:14]];
		r = '0;
		if (w.rom)
		begin
			r.csrom = 1'b1;
			r.rompg = {w.page[3:0], model_dos};
		end
		else
		begin
			r.ram_addr = {w.page, a.addr[13:0]};
		end
		r.wr = (a.kind == zx_bus_pkg::ACC_MEM_WR);
		return r;
	endfunction

	function automatic zx_bus_pkg::io_rd_t ref_rd(input zx_bus_pkg::z80_acc_t a);
		logic [7:0] sel;
		sel = a.addr[15:8];
		if (a.addr[7:0] != 8'hBE)
			return 8'hFF;
		if (sel < 8'd4)
			return zx_bus_pkg::io_rd_t'(model_win[sel[1:0]]);
		if (sel == 8'd4)
			return {3'b000, model_dos, model_win[3].rom, model_win[2].rom,
				model_win[1].rom, model_win[0].rom};
		return 8'hFF;
	endfunction

	// state change after the expected result is taken
	task automatic model_update(input zx_bus_pkg::z80_acc_t a);
		logic rom;
		rom = model_win[a.addr[15:14]].rom;
		if (a.kind == zx_bus_pkg::ACC_IO_WR && a.addr[7:0] == 8'hF7)
		begin
			model_win[a.addr[15:14]].zero = 1'b0;
			model_win[a.addr[15:14]].rom  = a.wdata[6];
			model_win[a.addr[15:14]].page = a.wdata[5:0];
		end
		else if (a.kind == zx_bus_pkg::ACC_M1)
		begin
			if (rom && a.addr[15:8] == 8'h3D)
				model_dos = 1'b1;
			else if (!rom)
				model_dos = 1'b0;
		end
	endtask

	//////////////////////////////////////////////////
	// checks and reporting
	//////////////////////////////////////////////////

	task automatic report_error(input string msg);
		n_errors++;
		$display("ERROR at %0t ns: %s", $time, msg);
	endtask

	task automatic check_mem(input zx_mem_pkg::mem_req_t got, input zx_mem_pkg::mem_req_t exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("MISMATCH at %0t ns: mem got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic check_rd(input zx_bus_pkg::io_rd_t got, input zx_bus_pkg::io_rd_t exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("MISMATCH at %0t ns: rd_data got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic start_test();
		test_err0 = n_errors;
	endtask

	task automatic end_test(input string name);
		n_tests++;
		$display("[%0t ns] test %-12s %0d errors", $time, name, n_errors - test_err0);
	endtask

	// outputs are stable just after the rising edge
	initial
	begin
		forever
		begin
			@(posedge fclk);
			#1;
			if (mem_valid === 1'b1)
			begin
				if (exp_mem_q.size() == 0)
					report_error("mem_valid without a memory access");
				else
					check_mem(mem, exp_mem_q.pop_front());
			end
			if (rd_valid === 1'b1)
			begin
				if (exp_rd_q.size() == 0)
					report_error("rd_valid without an I/O read");
				else
					check_rd(rd_data, exp_rd_q.pop_front());
			end
			if (exp_mem_q.size() != 0)
			begin
				report_error("no mem_valid one cycle after a memory access");
				exp_mem_q.delete();
			end
			if (exp_rd_q.size() != 0)
			begin
				report_error("no rd_valid one cycle after an I/O read");
				exp_rd_q.delete();
			end
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		return $random(seed);
	endfunction

	// one strobe on a falling edge followed by an idle cycle
	task automatic do_acc(input zx_bus_pkg::acc_kind_e kind, input logic [15:0] addr,
		input logic [7:0] wdata);
		zx_bus_pkg::z80_acc_t a;
		a.addr  = addr;
		a.wdata = wdata;
		a.kind  = kind;
		@(negedge fclk);
		acc_stb = 1'b1;
		acc     = a;
		if (kind == zx_bus_pkg::ACC_M1 || kind == zx_bus_pkg::ACC_MEM_RD ||
			kind == zx_bus_pkg::ACC_MEM_WR)
			exp_mem_q.push_back(ref_mem(a));
		else if (kind == zx_bus_pkg::ACC_IO_RD)
			exp_rd_q.push_back(ref_rd(a));
		model_update(a);
		@(negedge fclk);
		acc_stb = 1'b0;
	endtask

	initial
	begin
		#(WD_CYCLES * PERIOD);
		$display("watchdog expired after %0d cycles, run did not complete", WD_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

	initial
	begin
		logic [31:0]           r;
		logic [7:0]            port;
		logic [7:0]            sel;
		zx_bus_pkg::acc_kind_e k;
		logic                  prev;
		int                    n;

		seed     = 11608;
		n_tests  = 0;
		n_checks = 0;
		n_errors = 0;
		rst_n    = 1'b0;
		acc_stb  = 1'b0;
		acc      = '0;
		model_reset();

		// reset stretch and AY divider
		start_test();
		repeat (8) @(negedge fclk);
		if (res !== 1'b1)
			report_error("res is not high while rst_n is low");
		rst_n = 1'b1;
		// strobes of every kind during the stretch must be ignored
		acc_stb   = 1'b1;
		acc.addr  = 16'h3DF7;
		acc.wdata = 8'h2A;
		acc.kind  = zx_bus_pkg::ACC_M1;
		n = 0;
		do
		begin
			@(posedge fclk);
			#1;
			n++;
			if (ay_clk !== 1'b0)
				report_error("ay_clk not held low during reset");
			@(negedge fclk);
			acc.kind = zx_bus_pkg::acc_kind_e'(3'(n % 5));
		end while (res === 1'b1 && n < 200);
		acc_stb = 1'b0;
		if (n != 64)
			report_error($sformatf("res stayed high %0d cycles instead of 64", n));
		prev = ay_clk;
		for (int t = 0; t < 4; t++)
		begin
			n = 0;
			do
			begin
				@(posedge fclk);
				#1;
				n++;
			end while (ay_clk === prev && n < 20);
			if (n != 8)
				report_error($sformatf("ay_clk changed after %0d cycles instead of 8", n));
			prev = ay_clk;
		end
		end_test("reset");

		// readback and translation of the reset mapping
		start_test();
		for (int s = 0; s < 5; s++)
			do_acc(zx_bus_pkg::ACC_IO_RD, {8'(s), 8'hBE}, 8'h00);
		for (int w = 0; w < 4; w++)
		begin
			r = next_rand();
			do_acc(zx_bus_pkg::ACC_MEM_RD, {2'(w), r[13:0]}, 8'h00);
		end
		end_test("reset_cfg");

		start_test();
		for (int i = 0; i < N_RAND; i++)
		begin
			r = next_rand();
			do_acc(zx_bus_pkg::ACC_IO_WR, {r[15:8], 8'hF7}, r[23:16]);
			do_acc(zx_bus_pkg::ACC_IO_RD, {6'd0, r[15:14], 8'hBE}, 8'h00);
			r = next_rand();
			case (r[17:16])
				2'd0:    k = zx_bus_pkg::ACC_M1;
				2'd1:    k = zx_bus_pkg::ACC_MEM_RD;
				default: k = zx_bus_pkg::ACC_MEM_WR;
			endcase
			do_acc(k, r[15:0], r[31:24]);
		end
		end_test("paging");

		// window 0 on ROM page 2 and window 1 on RAM page 5
		start_test();
		do_acc(zx_bus_pkg::ACC_IO_WR, 16'h00F7, 8'h42);
		do_acc(zx_bus_pkg::ACC_IO_WR, 16'h40F7, 8'h05);
		r = next_rand();
		do_acc(zx_bus_pkg::ACC_M1, {2'b01, r[13:0]}, 8'h00);
		do_acc(zx_bus_pkg::ACC_IO_RD, 16'h04BE, 8'h00);
		do_acc(zx_bus_pkg::ACC_M1, {8'h3D, r[23:16]}, 8'h00);
		do_acc(zx_bus_pkg::ACC_MEM_RD, {2'b00, r[29:16]}, 8'h00);
		do_acc(zx_bus_pkg::ACC_IO_RD, 16'h04BE, 8'h00);
		do_acc(zx_bus_pkg::ACC_M1, {2'b01, r[31:18]}, 8'h00);
		do_acc(zx_bus_pkg::ACC_MEM_RD, {2'b00, r[13:0]}, 8'h00);
		do_acc(zx_bus_pkg::ACC_IO_RD, 16'h04BE, 8'h00);
		end_test("dos");

		start_test();
		for (int i = 0; i < N_UNM; i++)
		begin
			r = next_rand();
			port = r[7:0];
			if (port == 8'hBE)
				port = 8'h1F;
			do_acc(zx_bus_pkg::ACC_IO_RD, {r[15:8], port}, 8'h00);
			sel = r[23:16];
			if (sel < 8'd5)
				sel = sel + 8'd5;
			do_acc(zx_bus_pkg::ACC_IO_RD, {sel, 8'hBE}, 8'h00);
			r = next_rand();
			do_acc(zx_bus_pkg::ACC_MEM_WR, r[15:0], r[23:16]);
			port = r[31:24];
			if (port == 8'hF7)
				port = 8'hFE;
			do_acc(zx_bus_pkg::ACC_IO_WR, {r[15:8], port}, r[23:16]);
		end
		end_test("unmapped");

		repeat (2) @(negedge fclk);
		$display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
			n_tests, n_checks, n_errors, dut.u_sva.sva_fails);
		if (n_errors == 0 && dut.u_sva.sva_fails == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* test/zx_top_sva.sv */
//////////////////////////////////////////////////
// bus protocol assertions on the paging core
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module zx_top_sva (
	input wire                  fclk,
	input wire                  rst_n,
	input wire                  acc_stb,
	input zx_bus_pkg::z80_acc_t acc,
	input wire                  mem_valid,
	input wire                  rd_valid,
	input wire                  res
);

	// count of failed assertions
	int unsigned sva_fails = 0;

	// nothing comes out while the core is held in reset
	a_no_valid_in_reset: assert property (@(posedge fclk) disable iff (!rst_n)
		res |-> !mem_valid && !rd_valid)
	else
	begin
		sva_fails++;
		$error("valid output while res is high");
	end

	// read data only right after an I/O read strobe
	a_rd_after_io_rd: assert property (@(posedge fclk) disable iff (!rst_n)
		rd_valid |-> $past(acc_stb && acc.kind == zx_bus_pkg::ACC_IO_RD))
	else
	begin
		sva_fails++;
		$error("rd_valid without an I/O read one cycle earlier");
	end

	// memory request only right after M1, read or write
	a_mem_after_mem_acc: assert property (@(posedge fclk) disable iff (!rst_n)
		mem_valid |-> $past(acc_stb && (acc.kind == zx_bus_pkg::ACC_M1 ||
			acc.kind == zx_bus_pkg::ACC_MEM_RD || acc.kind == zx_bus_pkg::ACC_MEM_WR)))
	else
	begin
		sva_fails++;
		$error("mem_valid without a memory access one cycle earlier");
	end

endmodule

bind zx_top zx_top_sva u_sva (
	.fclk      (fclk     ),
	.rst_n     (rst_n    ),
	.acc_stb   (acc_stb  ),
	.acc       (acc      ),
	.mem_valid (mem_valid),
	.rd_valid  (rd_valid ),
	.res       (res      )
);

`default_nettype wire
